//--- tb/tapnw_testdata.txt
// kind length shift_in expected_out expected_select, every field hex
// kind 1 IR scan, 2 DR scan, 3 reset walk, 4 idle, 0 end of records
// Master IDCODE after reset
2 20 0 12345679 0
// TAPNW_SEL into the master, capture pattern back
1 4 2 1 0
// Enable slave 0, old selection reads back as 0
2 2 1 0 1
// IDCODE into slave 0 and master
1 8 11 11 1
2 40 0 1234567911111111 1
// TAPNW_SEL in the master, BYPASS in slave 0
1 8 2F 11 1
// Enable both slaves, selection 01 behind the slave bypass bit
2 3 6 2 3
// BYPASS in all three TAPs
1 C FFF 111 3
2 10 A5C3 2E18 3
// IDCODE in all three TAPs
1 C 111 111 3
2 60 0 123456791111111122222223 3
// Five tms high cycles back to Test-Logic-Reset
3 5 0 0 0
2 20 0 12345679 0
4 3 0 0 0
0 0 0 0 0

//--- filelist.f
+incdir+source
source/tapnw_pkg.sv
source/tap_fsm.sv
source/mtap.sv
source/stap.sv
source/tapnw_router.sv
source/tapnw_top.sv
tb/tapnw_properties.sv
tb/tapnw_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the TAP network testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f filelist.f --top-module tapnw_tb -o tapnw_sim || exit 1

result=$(./obj_dir/tapnw_sim 2>&1)
echo "$result"

echo "$result" | grep -q "^Simulation completed successfully$" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb/tapnw_tb.sv
// TAP network testbench
// Reads scan records from a data file, walks the JTAG pins
// through each record and checks tdo, tdo_en and the
// active slave selection

`timescale 1ns/100ps

module tapnw_tb;
    import tapnw_pkg::*;

    localparam int max_records      = 32;
    localparam int words_per_record = 5;
    localparam int shift_timeout    = 8;

    // Record kinds in the data file
    localparam int kind_end   = 0;
    localparam int kind_ir    = 1;
    localparam int kind_dr    = 2;
    localparam int kind_reset = 3;
    localparam int kind_idle  = 4;

    logic       tck;
    logic       rst;
    logic       tms;
    logic       tdi;
    logic       tdo;
    logic       tdo_en;
    tapnw_sel_t tapnw_enabletap;

    // Five words per record
    logic [95:0] records [max_records*words_per_record];

    tapnw_top u_dut (
        .tck             (tck),
        .rst             (rst),
        .tms             (tms),
        .tdi             (tdi),
        .tdo             (tdo),
        .tdo_en          (tdo_en),
        .tapnw_enabletap (tapnw_enabletap)
    );

    initial begin
        tck = 1'b0;
        forever #2 tck = ~tck;
    end

    // ------------------------------
    // Pin helpers
    // ------------------------------
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // Called 1 ns after an edge and returns 1 ns after the next
    task automatic clock_edge(input logic tms_v, input logic tdi_v);
        tms = tms_v;
        tdi = tdi_v;
        @(posedge tck);
        #1;
    endtask

    task automatic check_tdo_en(input logic expected);
        assert (tdo_en === expected) else
            stop_on_error($sformatf("Error: tdo_en expected %h got %h", expected, tdo_en));
    endtask

    task automatic check_select(input tapnw_sel_t expected);
        assert (tapnw_enabletap === expected) else
            stop_on_error($sformatf("Error: tapnw_enabletap expected %h got %h",
                                    expected, tapnw_enabletap));
    endtask

    // ------------------------------
    // Scan sequences
    // ------------------------------
    // Starts and ends in Run-Test/Idle with one extra idle edge
    // so a new selection reaches the router before the next scan
    task automatic run_scan(input logic is_ir, input int len,
                            input logic [95:0] data_in, input logic [95:0] expected);
        logic [95:0] got;
        int          wait_count;

        got        = '0;
        wait_count = 0;
        check_tdo_en(1'b0);
        clock_edge(1'b1, 1'b0);
        // Select-DR on to Select-IR
        if (is_ir) begin
            check_tdo_en(1'b0);
            clock_edge(1'b1, 1'b0);
        end
        check_tdo_en(1'b0);
        clock_edge(1'b0, 1'b0);
        // Leave Capture and wait for the shift window to open
        while (tdo_en !== 1'b1) begin
            assert (wait_count < shift_timeout) else
                stop_on_error("Timeout while waiting for the master to enter a Shift state");
            clock_edge(1'b0, 1'b0);
            wait_count++;
        end
        assert (wait_count > 0) else
            stop_on_error("tdo_en went high before the controller left Capture");
        // LSB first with tms high on the last bit
        for (int i = 0; i < len; i++) begin
            check_tdo_en(1'b1);
            got[i] = tdo;
            clock_edge(i == len - 1, data_in[i]);
        end
        // Exit1, Update, then Run-Test/Idle twice
        check_tdo_en(1'b0);
        clock_edge(1'b1, 1'b0);
        check_tdo_en(1'b0);
        clock_edge(1'b0, 1'b0);
        check_tdo_en(1'b0);
        clock_edge(1'b0, 1'b0);
        assert (got === expected) else
            stop_on_error($sformatf("Error: tdo scan out expected %h got %h", expected, got));
    endtask

    task automatic walk_reset(input int len);
        for (int i = 0; i < len; i++) begin
            check_tdo_en(1'b0);
            clock_edge(1'b1, 1'b0);
        end
        // Back to Run-Test/Idle plus one idle edge
        check_tdo_en(1'b0);
        clock_edge(1'b0, 1'b0);
        check_tdo_en(1'b0);
        clock_edge(1'b0, 1'b0);
    endtask

    task automatic run_idle(input int len);
        for (int i = 0; i < len; i++) begin
            check_tdo_en(1'b0);
            clock_edge(1'b0, 1'b0);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int  idx;
        int  base;
        int  kind;
        int  len;
        logic done;

        tms  = 1'b0;
        tdi  = 1'b0;
        rst  = 1'b1;
        idx  = 0;
        done = 1'b0;
        for (int i = 0; i < max_records*words_per_record; i++) begin
            records[i] = '0;
        end
        $readmemh("tb/tapnw_testdata.txt", records);
        assert (records[0][7:0] != 8'h0) else
            stop_on_error("The test data file holds no records");

        repeat (8) @(posedge tck);
        #1;
        rst = 1'b0;

        // Network idle and unselected straight after reset
        check_tdo_en(1'b0);
        check_select('0);
        // Test-Logic-Reset to Run-Test/Idle
        clock_edge(1'b0, 1'b0);

        while (!done && idx < max_records) begin
            base = idx * words_per_record;
            kind = int'(records[base][7:0]);
            len  = int'(records[base + 1][7:0]);
            case (kind)
                kind_end:   done = 1'b1;
                kind_ir:    run_scan(1'b1, len, records[base + 2], records[base + 3]);
                kind_dr:    run_scan(1'b0, len, records[base + 2], records[base + 3]);
                kind_reset: walk_reset(len);
                kind_idle:  run_idle(len);
                default:    stop_on_error("Unknown record kind in the test data file");
            endcase
            if (!done) begin
                check_select(records[base + 4][1:0]);
            end
            idx++;
        end

        // Bound network control assertions feed the final verdict
        if (u_dut.u_properties.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_on_error("A bound assertion on the network control failed");
        end
    end

endmodule

//--- tb/tapnw_properties.sv
// TAP network assertions
// Checks tdo_en against the master's shift phase and when
// the active slave selection may change

`timescale 1ns/100ps

module tapnw_properties (
    input logic                  tck,
    input logic                  rst,
    input logic                  tdo_en,
    input tapnw_pkg::tap_phase_t mtap_phase,
    input tapnw_pkg::tapnw_sel_t tapnw_enabletap
);

    // Failed assertions seen so far, read at the end of the run
    int fail_count = 0;

    // Output enable tracks Shift-IR and Shift-DR of the master
    a_tdo_en_shift: assert property (
        @(posedge tck) disable iff (rst)
        tdo_en == (mtap_phase.shift_dr | mtap_phase.shift_ir)
    ) else begin
        fail_count = fail_count + 1;
        $error("tdo_en does not follow the master shift states");
    end

    // Selection moves only on an edge out of Run-Test/Idle or Test-Logic-Reset
    a_sel_change: assert property (
        @(posedge tck) disable iff (rst)
        (tapnw_enabletap != $past(tapnw_enabletap)) |->
            ($past(mtap_phase.run_test_idle) || $past(mtap_phase.test_logic_reset))
    ) else begin
        fail_count = fail_count + 1;
        $error("tapnw_enabletap changed outside Run-Test/Idle and Test-Logic-Reset");
    end

    // Cleared by reset
    a_sel_after_rst: assert property (
        @(posedge tck) $past(rst) |-> (tapnw_enabletap == '0)
    ) else begin
        fail_count = fail_count + 1;
        $error("tapnw_enabletap not cleared after reset");
    end

endmodule

bind tapnw_top tapnw_properties u_properties (
    .tck             (tck),
    .rst             (rst),
    .tdo_en          (tdo_en),
    .mtap_phase      (mtap_phase),
    .tapnw_enabletap (tapnw_enabletap)
);

//--- source/tapnw_top.sv
// TAP network top level
// Master TAP, router and two slave TAPs on a single
// JTAG port with a shared tck and synchronous reset

`timescale 1ns/100ps
`include "tapnw_config.svh"

module tapnw_top (
    input  logic                  tck,
    input  logic                  rst,
    input  logic                  tms,
    input  logic                  tdi,
    output logic                  tdo,
    output logic                  tdo_en,
    output tapnw_pkg::tapnw_sel_t tapnw_enabletap
);
    import tapnw_pkg::*;

    tap_drive_t mtap_drive;
    tap_resp_t  mtap_resp;
    // Master phase, visible here for bound checks
    tap_phase_t mtap_phase;
    tap_drive_t stap_drive [`TAPNW_NUM_STAPS];
    tap_resp_t  stap_resp  [`TAPNW_NUM_STAPS];

    // Pins feed the master directly
    assign mtap_drive.tms = tms;
    assign mtap_drive.tdi = tdi;

    // ------------------------------
    // Master and router
    // ------------------------------
    mtap u_mtap (
        .tck       (tck),
        .rst       (rst),
        .drive     (mtap_drive),
        .resp      (mtap_resp),
        .phase     (mtap_phase),
        .enabletap (tapnw_enabletap)
    );

    tapnw_router u_router (
        .tms        (tms),
        .mtap_resp  (mtap_resp),
        .enabletap  (tapnw_enabletap),
        .stap_drive (stap_drive),
        .stap_resp  (stap_resp),
        .tdo        (tdo),
        .tdo_en     (tdo_en)
    );

    // ------------------------------
    // Slaves
    // ------------------------------
    stap #(.idcode(`STAP0_IDCODE)) u_stap0 (
        .tck   (tck),
        .rst   (rst),
        .drive (stap_drive[0]),
        .resp  (stap_resp[0])
    );

    stap #(.idcode(`STAP1_IDCODE)) u_stap1 (
        .tck   (tck),
        .rst   (rst),
        .drive (stap_drive[1]),
        .resp  (stap_resp[1])
    );

endmodule

//--- source/tapnw_router.sv
// TAP network router
// Gates tms to each slave TAP by its enable bit and threads
// the scan chain from the master through the enabled slaves
// in ascending order, all combinational

`timescale 1ns/100ps
`include "tapnw_config.svh"

module tapnw_router (
    input  logic                  tms,
    input  tapnw_pkg::tap_resp_t  mtap_resp,
    input  tapnw_pkg::tapnw_sel_t enabletap,
    output tapnw_pkg::tap_drive_t stap_drive [`TAPNW_NUM_STAPS],
    input  tapnw_pkg::tap_resp_t  stap_resp  [`TAPNW_NUM_STAPS],
    output logic                  tdo,
    output logic                  tdo_en
);

    // ------------------------------
    // Chain build
    // ------------------------------
    always_comb begin
        logic chain_bit;

        // Chain starts at the master's shift register
        chain_bit = mtap_resp.tdo;
        for (int i = 0; i < `TAPNW_NUM_STAPS; i++) begin
            // Disabled slave sees tms low and parks in Run-Test/Idle
            stap_drive[i].tms = tms & enabletap[i];
            stap_drive[i].tdi = chain_bit;
            // Enabled slave splices its register into the chain
            if (enabletap[i] && stap_resp[i].tdo_en) begin
                chain_bit = stap_resp[i].tdo;
            end
        end
        tdo = chain_bit;
    end

    // Enabled slaves shift in step with the master
    assign tdo_en = mtap_resp.tdo_en;

endmodule

//--- source/stap.sv
// Slave TAP
// Instruction register with IDCODE and BYPASS only, fed by
// the TAP network router

`timescale 1ns/100ps
`include "tapnw_config.svh"

module stap #(
    parameter tapnw_pkg::tap_idcode_t idcode = 32'h0000_0001
) (
    input  logic                  tck,
    input  logic                  rst,
    input  tapnw_pkg::tap_drive_t drive,
    output tapnw_pkg::tap_resp_t  resp
);
    import tapnw_pkg::*;

    tap_phase_t  phase;
    tap_ir_t     ir;
    tap_ir_t     ir_shift;
    tap_idcode_t idcode_shift;
    logic        bypass_bit;
    logic        dr_tdo;

    tap_fsm u_fsm (
        .tck   (tck),
        .rst   (rst),
        .tms   (drive.tms),
        .state (),
        .phase (phase)
    );

    // ------------------------------
    // Instruction register
    // ------------------------------
    always_ff @(posedge tck) begin
        if (rst || phase.test_logic_reset) begin
            ir <= `TAP_IR_IDCODE;
        end else if (phase.update_ir) begin
            ir <= ir_shift;
        end
    end

    always_ff @(posedge tck) begin
        if (phase.capture_ir) begin
            ir_shift <= `TAP_IR_CAPTURE;
        end else if (phase.shift_ir) begin
            ir_shift <= {drive.tdi, ir_shift[`TAP_IR_WIDTH-1:1]};
        end
    end

    // ------------------------------
    // Data registers
    // ------------------------------
    always_ff @(posedge tck) begin
        if (phase.capture_dr) begin
            idcode_shift <= idcode;
        end else if (phase.shift_dr && (ir == `TAP_IR_IDCODE)) begin
            idcode_shift <= {drive.tdi, idcode_shift[31:1]};
        end
    end

    // Single bit path through the slave
    always_ff @(posedge tck) begin
        if (phase.capture_dr) begin
            bypass_bit <= 1'b0;
        end else if (phase.shift_dr) begin
            bypass_bit <= drive.tdi;
        end
    end

    // Output mux, anything not IDCODE takes the bypass bit
    always_comb begin
        case (ir)
            `TAP_IR_IDCODE: dr_tdo = idcode_shift[0];
            `TAP_IR_BYPASS: dr_tdo = bypass_bit;
            default:        dr_tdo = bypass_bit;
        endcase
    end

    assign resp.tdo    = phase.shift_ir ? ir_shift[0] : dr_tdo;
    assign resp.tdo_en = phase.shift_ir | phase.shift_dr;

endmodule

//--- source/mtap.sv
// Master TAP
// Instruction register with IDCODE, BYPASS and TAPNW_SEL,
// plus the pending and active slave select registers that
// steer the TAP network router

`timescale 1ns/100ps
`include "tapnw_config.svh"

module mtap (
    input  logic                  tck,
    input  logic                  rst,
    input  tapnw_pkg::tap_drive_t drive,
    output tapnw_pkg::tap_resp_t  resp,
    output tapnw_pkg::tap_phase_t phase,
    output tapnw_pkg::tapnw_sel_t enabletap
);
    import tapnw_pkg::*;

    tap_ir_t     ir;
    tap_ir_t     ir_shift;
    tap_idcode_t idcode_shift;
    logic        bypass_bit;
    tapnw_sel_t  sel_shift;
    tapnw_sel_t  sel_pending;
    logic        is_idcode;
    logic        is_tapnw_sel;
    logic        dr_tdo;

    tap_fsm u_fsm (
        .tck   (tck),
        .rst   (rst),
        .tms   (drive.tms),
        .state (),
        .phase (phase)
    );

    // ------------------------------
    // Instruction register
    // ------------------------------
    always_ff @(posedge tck) begin
        if (rst || phase.test_logic_reset) begin
            ir <= `TAP_IR_IDCODE;
        end else if (phase.update_ir) begin
            ir <= ir_shift;
        end
    end

    // IR shift stage, LSB goes out first
    always_ff @(posedge tck) begin
        if (phase.capture_ir) begin
            ir_shift <= `TAP_IR_CAPTURE;
        end else if (phase.shift_ir) begin
            ir_shift <= {drive.tdi, ir_shift[`TAP_IR_WIDTH-1:1]};
        end
    end

    assign is_idcode    = (ir == `TAP_IR_IDCODE);
    assign is_tapnw_sel = (ir == `TAP_IR_TAPNW_SEL);

    // ------------------------------
    // Data registers
    // ------------------------------
    always_ff @(posedge tck) begin
        if (phase.capture_dr) begin
            idcode_shift <= `MTAP_IDCODE;
        end else if (phase.shift_dr && is_idcode) begin
            idcode_shift <= {drive.tdi, idcode_shift[31:1]};
        end
    end

    // Bypass captures 0, then delays tdi by one bit
    always_ff @(posedge tck) begin
        if (phase.capture_dr) begin
            bypass_bit <= 1'b0;
        end else if (phase.shift_dr) begin
            bypass_bit <= drive.tdi;
        end
    end

    // Select DR reads back the active selection
    always_ff @(posedge tck) begin
        if (phase.capture_dr) begin
            sel_shift <= enabletap;
        end else if (phase.shift_dr && is_tapnw_sel) begin
            sel_shift <= {drive.tdi, sel_shift[`TAPNW_NUM_STAPS-1:1]};
        end
    end

    // Pending value waits for Run-Test/Idle before it
    // reaches the router, so slaves join in a known state
    always_ff @(posedge tck) begin
        if (rst || phase.test_logic_reset) begin
            sel_pending <= '0;
            enabletap   <= '0;
        end else begin
            if (phase.update_dr && is_tapnw_sel) begin
                sel_pending <= sel_shift;
            end
            if (phase.run_test_idle) begin
                enabletap <= sel_pending;
            end
        end
    end

    // ------------------------------
    // Serial output
    // ------------------------------
    always_comb begin
        case (ir)
            `TAP_IR_IDCODE:    dr_tdo = idcode_shift[0];
            `TAP_IR_TAPNW_SEL: dr_tdo = sel_shift[0];
            `TAP_IR_BYPASS:    dr_tdo = bypass_bit;
            // Unknown opcodes behave as BYPASS
            default:           dr_tdo = bypass_bit;
        endcase
    end

    assign resp.tdo    = phase.shift_ir ? ir_shift[0] : dr_tdo;
    assign resp.tdo_en = phase.shift_ir | phase.shift_dr;

endmodule

//--- source/tap_fsm.sv
// TAP controller
// 16-state 1149.1 controller stepping on every rising tck,
// with the states the data path acts on decoded into flags

`timescale 1ns/100ps

module tap_fsm (
    input  logic                  tck,
    input  logic                  rst,
    input  logic                  tms,
    output tapnw_pkg::tap_state_e state,
    output tapnw_pkg::tap_phase_t phase
);
    import tapnw_pkg::*;

    tap_state_e next_state;

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        case (state)
            st_tlr:      next_state = tms ? st_tlr      : st_rti;
            st_rti:      next_state = tms ? st_sel_dr   : st_rti;
            // DR column
            st_sel_dr:   next_state = tms ? st_sel_ir   : st_cap_dr;
            st_cap_dr:   next_state = tms ? st_exit1_dr : st_shift_dr;
            st_shift_dr: next_state = tms ? st_exit1_dr : st_shift_dr;
            st_exit1_dr: next_state = tms ? st_upd_dr   : st_pause_dr;
            st_pause_dr: next_state = tms ? st_exit2_dr : st_pause_dr;
            st_exit2_dr: next_state = tms ? st_upd_dr   : st_shift_dr;
            st_upd_dr:   next_state = tms ? st_sel_dr   : st_rti;
            // IR column
            st_sel_ir:   next_state = tms ? st_tlr      : st_cap_ir;
            st_cap_ir:   next_state = tms ? st_exit1_ir : st_shift_ir;
            st_shift_ir: next_state = tms ? st_exit1_ir : st_shift_ir;
            st_exit1_ir: next_state = tms ? st_upd_ir   : st_pause_ir;
            st_pause_ir: next_state = tms ? st_exit2_ir : st_pause_ir;
            st_exit2_ir: next_state = tms ? st_upd_ir   : st_shift_ir;
            st_upd_ir:   next_state = tms ? st_sel_dr   : st_rti;
            default:     next_state = st_tlr;
        endcase
    end

    // State register, reset parks in Test-Logic-Reset
    always_ff @(posedge tck) begin
        if (rst) begin
            state <= st_tlr;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------
    // Phase decode
    // ------------------------------
    // Flags follow the current state, so a register acting on
    // them does so on the edge that leaves the state
    assign phase.test_logic_reset = (state == st_tlr);
    assign phase.run_test_idle    = (state == st_rti);
    assign phase.capture_dr       = (state == st_cap_dr);
    assign phase.shift_dr         = (state == st_shift_dr);
    assign phase.update_dr        = (state == st_upd_dr);
    assign phase.capture_ir       = (state == st_cap_ir);
    assign phase.shift_ir         = (state == st_shift_ir);
    assign phase.update_ir        = (state == st_upd_ir);

endmodule

//--- source/tapnw_pkg.sv
// TAP network types
// Controller state encoding, vector types and the packed
// structs that carry serial data between the TAPs

`include "tapnw_config.svh"

package tapnw_pkg;

    // 1149.1 state encoding
    typedef enum logic [3:0] {
        st_exit2_dr  = 4'h0,
        st_exit1_dr  = 4'h1,
        st_shift_dr  = 4'h2,
        st_pause_dr  = 4'h3,
        st_sel_ir    = 4'h4,
        st_upd_dr    = 4'h5,
        st_cap_dr    = 4'h6,
        st_sel_dr    = 4'h7,
        st_exit2_ir  = 4'h8,
        st_exit1_ir  = 4'h9,
        st_shift_ir  = 4'hA,
        st_pause_ir  = 4'hB,
        st_rti       = 4'hC,
        st_upd_ir    = 4'hD,
        st_cap_ir    = 4'hE,
        st_tlr       = 4'hF
    } tap_state_e;

    typedef logic [`TAP_IR_WIDTH-1:0]    tap_ir_t;
    typedef logic [31:0]                 tap_idcode_t;
    // One enable bit per slave TAP
    typedef logic [`TAPNW_NUM_STAPS-1:0] tapnw_sel_t;

    // Decoded controller phase
    typedef struct packed {
        logic test_logic_reset;
        logic run_test_idle;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
    } tap_phase_t;

    // Serial input into one TAP
    typedef struct packed {
        logic tms;
        logic tdi;
    } tap_drive_t;

    // Serial output of one TAP
    typedef struct packed {
        logic tdo;
        logic tdo_en;
    } tap_resp_t;

endpackage

//--- source/tapnw_config.svh
// TAP network configuration
// Chain size, instruction register width, opcodes,
// capture pattern and the IDCODE values of every TAP

`ifndef TAPNW_CONFIG_SVH
`define TAPNW_CONFIG_SVH

// Number of slave TAPs behind the router
`define TAPNW_NUM_STAPS 2

// Instruction register width, shared by master and slaves
`define TAP_IR_WIDTH 4

// Opcodes
`define TAP_IR_IDCODE    4'h1
// Decoded in the master only
`define TAP_IR_TAPNW_SEL 4'h2
`define TAP_IR_BYPASS    4'hF

// Fixed pattern loaded into IR in Capture-IR
`define TAP_IR_CAPTURE 4'b0001

// IDCODE values, bit 0 set as 1149.1 requires
`define MTAP_IDCODE  32'h1234_5679
`define STAP0_IDCODE 32'h1111_1111
`define STAP1_IDCODE 32'h2222_2223

`endif
